// ==== lsab_macros.svh ====
`ifndef LSAB_MACROS_SVH
`define LSAB_MACROS_SVH

// longest block the mover takes in one issue
`define LSAB_BLOCK_LEN 24

// address split, page number above the word offset
`define LSAB_OFFS_W 12
`define LSAB_PAGE_W 2

// output stream credits after reset
`define LSAB_CREDITS 4

// precharge plus activate, in cycles
`define LSAB_OPEN_LAT 3

`endif

// ==== lsab_pkg.sv ====
`include "lsab_macros.svh"

package lsab_pkg;

  typedef logic [`LSAB_PAGE_W+`LSAB_OFFS_W-1:0] addr_t;  // word address
  typedef logic [`LSAB_PAGE_W-1:0]              page_t;
  typedef logic [`LSAB_OFFS_W-1:0]              offs_t;  // offset inside a page

  typedef logic [$clog2(`LSAB_BLOCK_LEN+1)-1:0] blen_t;  // 0 to 24 words
  typedef logic [`LSAB_PAGE_W+`LSAB_OFFS_W-1:0] xlen_t;  // transfer length
  typedef logic [1:0]                           section_t;
  typedef logic [31:0]                          word_t;
  typedef logic [$clog2(`LSAB_CREDITS+1)-1:0]   credit_t;

  // sequencer states
  typedef enum logic [2:0] {
    IDLE,
    ALIGN,      // page_req up, waiting on grant
    SIZE,
    ISSUE,
    WAIT_MOVE,
    NEXT
  } seq_state_t;

endpackage

// ==== block_if.sv ====
interface block_if
  import lsab_pkg::*;
();

  offs_t    start;       // first word of the block, page relative
  page_t    page;
  blen_t    count_req;
  section_t section;
  logic     issue;       // single cycle, only looked at while not working
  blen_t    count_sent;  // valid once working is low again
  logic     working;

  // sequencer side
  modport seq (
    output start, page, count_req, section, issue,
    input  count_sent, working
  );

  modport mover (
    input  start, page, count_req, section, issue,
    output count_sent, working
  );

endinterface

// ==== page_align_mcu.sv ====
`include "lsab_macros.svh"

module page_align_mcu
  import lsab_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,
  input  logic  page_req,
  input  page_t page_addr,
  output logic  page_grant
);

  localparam int LAT_W = $clog2(`LSAB_OPEN_LAT + 1);
  localparam logic [LAT_W-1:0] OPEN_LAT = LAT_W'(`LSAB_OPEN_LAT);

  page_t            open_page;   // row held in the buffer
  logic             open_valid;
  logic [LAT_W-1:0] lat_cnt;
  logic             hit;

  assign hit = open_valid && (open_page == page_addr);

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      open_page  <= '0;
      open_valid <= 1'b0;
      lat_cnt    <= '0;
      page_grant <= 1'b0;
    end
    else if (!page_req)
    begin
      page_grant <= 1'b0;
      lat_cnt    <= '0;
    end
    else if (!page_grant)
    begin
      if (hit)
        page_grant <= 1'b1;  // row already open
      else if (lat_cnt == OPEN_LAT)
      begin
        page_grant <= 1'b1;
        open_page  <= page_addr;
        open_valid <= 1'b1;
        lat_cnt    <= '0;
      end
      else
      begin
        // precharge the old row, then activate the new one
        if (lat_cnt == '0)
          open_valid <= 1'b0;
        lat_cnt <= lat_cnt + LAT_W'(1);
      end
    end
  end

endmodule

// ==== dram_block_seq.sv ====
`include "lsab_macros.svh"

module dram_block_seq
  import lsab_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  input  logic     cmd_valid,
  input  addr_t    cmd_addr,
  input  xlen_t    cmd_len,
  input  section_t cmd_section,
  output logic     cmd_ready,
  output logic     done,
  output logic     page_req,
  output page_t    page_addr,
  input  logic     page_grant,
  block_if.seq     blk
);

  localparam xlen_t PAGE_WORDS = xlen_t'(2 ** `LSAB_OFFS_W);

  seq_state_t state;
  addr_t      cur_addr;
  page_t      cur_page;
  offs_t      cur_offs;
  xlen_t      remain;    // words still to move
  section_t   sec_r;
  logic       working_prev;
  logic       move_done;
  xlen_t      to_end;
  blen_t      blk_len;

  assign {cur_page, cur_offs} = cur_addr;
  assign cmd_ready = (state == IDLE);
  assign move_done = working_prev && !blk.working;  // mover just went idle
  assign to_end = PAGE_WORDS - xlen_t'(cur_offs);

  // block size, never past the page end or the transfer end
  always_comb
  begin
    xlen_t lim;
    lim = xlen_t'(`LSAB_BLOCK_LEN);
    if (to_end < lim)
      lim = to_end;
    if (remain < lim)
      lim = remain;
    blk_len = blen_t'(lim);
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      state        <= IDLE;
      done         <= 1'b0;
      page_req     <= 1'b0;
      blk.issue    <= 1'b0;
      working_prev <= 1'b0;
    end
    else
    begin
      working_prev <= blk.working;
      done         <= 1'b0;
      blk.issue    <= 1'b0;
      case (state)
        IDLE:
          if (cmd_valid)
          begin
            if (cmd_len == '0)
              state <= NEXT;  // nothing to move, finish right away
            else
            begin
              page_req <= 1'b1;
              state    <= ALIGN;
            end
          end
        ALIGN:
          if (page_grant)
            state <= SIZE;
        SIZE:
        begin
          blk.issue <= 1'b1;
          state     <= ISSUE;
        end
        ISSUE:
          state <= WAIT_MOVE;
        WAIT_MOVE:
          if (move_done)
          begin
            page_req <= 1'b0;  // block finished, release the page
            state    <= NEXT;
          end
        NEXT:
          if (remain == '0)
          begin
            done  <= 1'b1;
            state <= IDLE;
          end
          else
          begin
            page_req <= 1'b1;
            state    <= ALIGN;
          end
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK)
  begin
    if (cmd_ready && cmd_valid)
    begin
      cur_addr  <= cmd_addr;
      remain    <= cmd_len;
      sec_r     <= cmd_section;
      page_addr <= cmd_addr[`LSAB_PAGE_W+`LSAB_OFFS_W-1:`LSAB_OFFS_W];
    end
    else if (state == WAIT_MOVE && move_done)
    begin
      cur_addr <= cur_addr + addr_t'(blk.count_sent);  // step by what really went out
      remain   <= remain - xlen_t'(blk.count_sent);
    end
    else if (state == NEXT)
      page_addr <= cur_page;

    if (state == SIZE)
    begin
      blk.start     <= cur_offs;
      blk.page      <= cur_page;
      blk.count_req <= blk_len;
      blk.section   <= sec_r;
    end
  end

endmodule

// ==== dram_block_mover.sv ====
`include "lsab_macros.svh"

module dram_block_mover
  import lsab_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  input  logic     wr_en,
  input  addr_t    wr_addr,
  input  word_t    wr_data,
  block_if.mover   blk,
  output logic     out_valid,
  output word_t    out_data,
  output section_t out_section,
  input  logic     credit_in
);

  localparam int DEPTH = 2 ** $bits(addr_t);

  word_t   mem [DEPTH];  // 16K words
  addr_t   rd_ptr;
  blen_t   left;         // words not yet fetched
  credit_t credit;
  logic    start_blk;
  logic    fetch;

  assign start_blk = blk.issue && !blk.working;
  // a credit is taken at fetch so the word can't outrun it
  assign fetch = blk.working && (left != '0) && (credit != '0);

  always_ff @(posedge CLK)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
  end

  always_ff @(posedge CLK)
  begin
    if (start_blk)
    begin
      rd_ptr      <= {blk.page, blk.start};
      out_section <= blk.section;
    end
    else if (fetch)
      rd_ptr <= rd_ptr + addr_t'(1);

    if (fetch)
      out_data <= mem[rd_ptr];  // shows up with out_valid next cycle
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      blk.working    <= 1'b0;
      blk.count_sent <= '0;
      left           <= '0;
      out_valid      <= 1'b0;
      credit         <= credit_t'(`LSAB_CREDITS);
    end
    else
    begin
      out_valid <= fetch;
      if (start_blk)
      begin
        left           <= blk.count_req;
        blk.count_sent <= '0;
        blk.working    <= (blk.count_req != '0);
      end
      else
      begin
        if (fetch)
          left <= left - blen_t'(1);
        if (out_valid)
          blk.count_sent <= blk.count_sent + blen_t'(1);
        if (blk.working && left == '0)
          blk.working <= 1'b0;  // last word is on the bus this cycle
      end

      case ({credit_in, fetch})
        2'b10:   credit <= credit + credit_t'(1);
        2'b01:   credit <= credit - credit_t'(1);
        default: credit <= credit;  // none or both
      endcase
    end
  end

endmodule

// ==== lsab_top.sv ====
module lsab_top
  import lsab_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  input  logic     cmd_valid,
  input  addr_t    cmd_addr,
  input  xlen_t    cmd_len,
  input  section_t cmd_section,
  output logic     cmd_ready,
  output logic     done,
  input  logic     wr_en,
  input  addr_t    wr_addr,
  input  word_t    wr_data,
  output logic     out_valid,
  output word_t    out_data,
  output section_t out_section,
  input  logic     credit_in
);

  logic  page_req;
  page_t page_addr;
  logic  page_grant;

  block_if blk_if ();

  dram_block_seq seq_i (
    .CLK         (CLK),
    .RST         (RST),
    .cmd_valid   (cmd_valid),
    .cmd_addr    (cmd_addr),
    .cmd_len     (cmd_len),
    .cmd_section (cmd_section),
    .cmd_ready   (cmd_ready),
    .done        (done),
    .page_req    (page_req),
    .page_addr   (page_addr),
    .page_grant  (page_grant),
    .blk         (blk_if)
  );

  // row buffer model
  page_align_mcu mcu_i (
    .CLK        (CLK),
    .RST        (RST),
    .page_req   (page_req),
    .page_addr  (page_addr),
    .page_grant (page_grant)
  );

  dram_block_mover mover_i (
    .CLK         (CLK),
    .RST         (RST),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .blk         (blk_if),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_section (out_section),
    .credit_in   (credit_in)
  );

endmodule

// ==== lsab_asserts.sv ====
`include "lsab_macros.svh"

module lsab_asserts
(
  input logic CLK,
  input logic RST,
  input logic cmd_valid,
  input logic cmd_ready,
  input logic done,
  input logic out_valid,
  input logic credit_in
);

  logic [3:0] credit_cnt;  // credits the stream may still spend
  logic       busy;        // between accept and done

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      credit_cnt <= 4'(`LSAB_CREDITS);
      busy       <= 1'b0;
    end
    else
    begin
      credit_cnt <= credit_cnt + 4'(credit_in) - 4'(out_valid);
      if (cmd_valid && cmd_ready)
        busy <= 1'b1;
      else if (done)
        busy <= 1'b0;
    end
  end

  assert property (@(posedge CLK) disable iff (!RST) out_valid |-> credit_cnt != '0)
    else $error("word sent with no credit left");

  assert property (@(posedge CLK) disable iff (!RST) (busy && !done) |-> !cmd_ready)
    else $error("cmd_ready high while a transfer runs");

  // done lasts one cycle only
  assert property (@(posedge CLK) disable iff (!RST) done |=> !done)
    else $error("done held longer than one cycle");

endmodule

bind lsab_top lsab_asserts asserts_i (
  .CLK       (CLK),
  .RST       (RST),
  .cmd_valid (cmd_valid),
  .cmd_ready (cmd_ready),
  .done      (done),
  .out_valid (out_valid),
  .credit_in (credit_in)
);

// ==== lsab_tb.sv ====
`include "lsab_macros.svh"

module lsab_tb
  import lsab_pkg::*;
();

  localparam int CREDIT_DLY = 3;     // cycles before a word's credit goes back
  localparam int TIMEOUT    = 4000;  // cycles per wait

  logic     CLK = 1'b0;
  logic     RST;
  logic     cmd_valid, cmd_ready, done, wr_en, out_valid;
  logic     credit_in = 1'b0;
  addr_t    cmd_addr, wr_addr;
  xlen_t    cmd_len;
  section_t cmd_section, out_section;
  word_t    wr_data, out_data;

  word_t                 ref_mem [2 ** $bits(addr_t)];  // copy of the DRAM array
  word_t                 rx_data [$];
  section_t              rx_sec [$];
  int                    done_cnt = 0;
  int                    owed = 0;  // credits due back to the DUT
  logic [CREDIT_DLY-1:0] ret_pipe = '0;
  logic                  credit_next = 1'b0;
  logic                  hold_credit;
  logic [31:0]           lfsr;

  lsab_top lsab_top_i (.*);

  always #2 CLK = ~CLK;

  // receive side, sampled away from the rising edge
  always @(negedge CLK)
  begin
    if (!RST)
    begin
      owed        = 0;
      ret_pipe    = '0;
      credit_next = 1'b0;
    end
    else
    begin
      if (out_valid)
      begin
        rx_data.push_back(out_data);
        rx_sec.push_back(out_section);
      end
      if (done)
        done_cnt++;
      if (ret_pipe[CREDIT_DLY-1])
        owed++;
      ret_pipe = {ret_pipe[CREDIT_DLY-2:0], out_valid};
      credit_next = !hold_credit && owed > 0;  // one credit per cycle at most
      if (credit_next)
        owed--;
    end
  end

  always @(posedge CLK)
  begin
    #1;
    credit_in = credit_next;
  end

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic word_t rand_word();
    word_t w;
    w = '0;
    for (int i = 0; i < 32; i++)
    begin
      lfsr = lfsr_next(lfsr);
      w = {w[30:0], lfsr[0]};
    end
    return w;
  endfunction

  task automatic give_up(string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act)
    begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!cmd_ready)
    begin
      @(posedge CLK);
      #1;
      n++;
      if (n > TIMEOUT)
        give_up("cmd_ready never came back");
    end
  endtask

  task automatic wait_done(int target);
    int n;
    n = 0;
    while (done_cnt < target)
    begin
      @(posedge CLK);
      #1;
      n++;
      if (n > TIMEOUT)
        give_up("done pulse never arrived");
    end
  endtask

  task automatic wait_words(int target);
    int n;
    n = 0;
    while (rx_data.size() < target)
    begin
      @(posedge CLK);
      #1;
      n++;
      if (n > TIMEOUT)
        give_up("output words stopped arriving");
    end
  endtask

  task automatic apply_reset();
    RST       = 1'b0;
    cmd_valid = 1'b0;
    repeat (16) @(posedge CLK);
    #1;
    RST = 1'b1;
  endtask

  task automatic load_words(addr_t base, int n);
    for (int i = 0; i < n; i++)
    begin
      @(posedge CLK);
      #1;
      wr_en   = 1'b1;
      wr_addr = base + addr_t'(i);
      wr_data = rand_word();
      ref_mem[wr_addr] = wr_data;
    end
    @(posedge CLK);
    #1;
    wr_en = 1'b0;
  endtask

  task automatic send_cmd(addr_t addr, xlen_t len, section_t sec);
    wait_ready();
    cmd_valid   = 1'b1;
    cmd_addr    = addr;
    cmd_len     = len;
    cmd_section = sec;
    @(posedge CLK);  // accepted on this edge
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic check_words(string name, addr_t base, int first, int n, section_t sec);
    for (int i = 0; i < n; i++)
    begin
      check(name, ref_mem[base + addr_t'(i)], rx_data[first + i]);
      check(name, 32'(sec), 32'(rx_sec[first + i]));
    end
  endtask

  task automatic run_and_check(string name, addr_t base, int len, section_t sec);
    int first;
    int target;
    first  = rx_data.size();
    target = done_cnt + 1;
    send_cmd(base, xlen_t'(len), sec);
    wait_done(target);
    check(name, first + len, rx_data.size());  // nothing after done
    check_words(name, base, first, len, sec);
  endtask

  task automatic test_single_block();
    run_and_check("test_single_block", 14'h0100, 10, 2'd1);
  endtask

  task automatic test_page_cross();
    run_and_check("test_page_cross", 14'h0ffb, 60, 2'd2);  // 5 words before the page end
  endtask

  task automatic test_backpressure();
    int first;
    int target;
    first       = rx_data.size();
    target      = done_cnt + 1;
    hold_credit = 1'b1;
    send_cmd(14'h2100, 14'd20, 2'd3);
    wait_words(first + `LSAB_CREDITS);
    repeat (20) @(posedge CLK);
    #1;
    check("test_backpressure", first + `LSAB_CREDITS, rx_data.size());
    check("test_backpressure", target - 1, done_cnt);
    hold_credit = 1'b0;
    wait_done(target);
    check("test_backpressure", first + 20, rx_data.size());
    check_words("test_backpressure", 14'h2100, first, 20, 2'd3);
  endtask

  task automatic test_back_to_back();
    int first;
    int target;
    first  = rx_data.size();
    target = done_cnt + 2;
    send_cmd(14'h2200, 14'd15, 2'd1);
    send_cmd(14'h2300, 14'd12, 2'd2);  // same page, goes as soon as ready
    wait_done(target);
    check("test_back_to_back", first + 27, rx_data.size());
    check_words("test_back_to_back", 14'h2200, first, 15, 2'd1);
    check_words("test_back_to_back", 14'h2300, first + 15, 12, 2'd2);
  endtask

  task automatic test_zero_and_reset();
    int first;
    int target;
    first  = rx_data.size();
    target = done_cnt + 1;
    send_cmd(14'h0200, 14'd0, 2'd1);
    wait_done(target);
    check("test_zero_and_reset", first, rx_data.size());
    // long transfer, cut short by reset
    send_cmd(14'h3000, 14'd300, 2'd2);
    wait_words(first + 30);
    apply_reset();
    repeat (10)
    begin
      check("test_zero_and_reset", 0, 32'(out_valid));
      check("test_zero_and_reset", 0, 32'(done));
      check("test_zero_and_reset", 1, 32'(cmd_ready));
      @(posedge CLK);
      #1;
    end
    run_and_check("test_zero_and_reset", 14'h0300, 8, 2'd0);
  endtask

  initial
  begin
    cmd_valid   = 1'b0;
    cmd_addr    = '0;
    cmd_len     = '0;
    cmd_section = '0;
    wr_en       = 1'b0;
    wr_addr     = '0;
    wr_data     = '0;
    hold_credit = 1'b0;
    lfsr        = 32'h1150_6278;
    apply_reset();
    load_words(14'h0100, 10);
    load_words(14'h0ffb, 60);
    load_words(14'h2100, 20);
    load_words(14'h2200, 15);
    load_words(14'h2300, 12);
    load_words(14'h0300, 8);
    test_single_block();
    test_page_cross();
    test_backpressure();
    test_back_to_back();
    test_zero_and_reset();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+.
lsab_pkg.sv
block_if.sv
page_align_mcu.sv
dram_block_seq.sv
dram_block_mover.sv
lsab_top.sv
lsab_asserts.sv
lsab_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lsab_tb -f sources.f -o lsab_sim

out=$(./obj_dir/lsab_sim || true)
echo "$out"
if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
fi
exit 1
